//--- freecell_tests.txt
# op arguments then test name; suits 0 hearts 1 spades 2 clubs 3 diamonds
# deal col suit rank | move src dst ok | view loc suit rank | cfg cells empty_any
# stat accepted rejected | stack col suit low high | drain col home count | win
deal 0 1 7 deal_s7
deal 1 0 9 deal_h9
deal 1 0 6 deal_h6
deal 2 3 5 deal_d5
deal 3 2 4 deal_c4
view 0 1 7 view_col0
view 1 0 6 view_col1
view 7 0 0 view_empty_col
view 8 0 0 view_empty_cell
view 12 0 0 view_empty_home
move 1 0 1 red6_on_black7
view 0 0 6 col0_gets_h6
view 1 0 9 col1_shows_h9
move 2 0 0 same_colour
move 3 0 0 wrong_rank
view 0 0 6 col0_unchanged
view 2 3 5 col2_unchanged
move 7 8 0 empty_source
move 0 0 0 same_location
stat 1 4 stat_tableau
move 2 8 1 into_free_cell
view 8 3 5 cell0_holds_d5
move 3 8 0 cell_occupied
cfg 2 1 two_cells
move 3 11 0 cell3_disabled
move 3 9 1 into_cell1
move 8 2 1 cell_to_empty_col
move 9 2 1 cell_back_to_column
view 2 2 4 col2_shows_c4
view 9 0 0 cell1_cleared
cfg 4 0 kings_only
move 2 3 0 non_king_empty_col
deal 4 0 13 deal_hk
move 4 3 1 king_empty_col
deal 5 0 2 deal_h2
deal 5 0 1 deal_h1
move 5 13 0 ace_wrong_suit
move 5 12 1 ace_home
move 1 12 0 home_rank_skip
move 5 12 1 two_home
move 12 6 0 from_home
view 12 0 2 home_hearts_two
stat 8 10 stat_cells_home
stack 4 0 3 13 stack_hearts
drain 4 12 11 drain_hearts
stack 5 1 1 13 stack_spades
drain 5 13 13 drain_spades
stack 6 2 1 13 stack_clubs
drain 6 14 13 drain_clubs
stack 7 3 1 13 stack_diamonds
drain 7 15 13 drain_diamonds
win win_flag
move 0 8 0 move_after_win
win win_stays
view 15 3 13 home_diamonds_king
stat 58 11 stat_final

//--- filelist.f
freecell_pkg.sv
rule_regs.sv
tableau_store.sv
cell_store.sv
move_engine.sv
freecell_top.sv
tb_freecell.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_freecell
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_freecell.sv
`timescale 1ns/1ps

module tb_freecell;
    import freecell_pkg::*;

    localparam int NAME_W     = 8 * 32;
    localparam int LINE_W     = 8 * 160;
    localparam int WAIT_LIMIT = 10;

    logic       clock;
    logic       arst_n;
    logic       cfg_write;
    logic [2:0] cfg_cells;
    logic       cfg_empty_any;
    logic       deal_valid;
    logic [2:0] deal_col;
    card_t      deal_card;
    logic       move_valid;
    loc_t       move_src;
    loc_t       move_dst;
    loc_t       view_loc;
    logic       move_done;
    logic       move_ok;
    logic       win;
    card_t      view_card;
    count_t     accepted_count;
    count_t     rejected_count;

    int         errors;
    int         checks;
    logic       aborted;

    freecell_top DUT (
        .clock, .arst_n, .cfg_write, .cfg_cells, .cfg_empty_any,
        .deal_valid, .deal_col, .deal_card, .move_valid, .move_src, .move_dst,
        .view_loc, .move_done, .move_ok, .win, .view_card,
        .accepted_count, .rejected_count
    );

    always #5 clock = ~clock;

    // Every command starts 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) next_cycle();
    endtask

    function automatic card_t make_card(input int suit, input int rank);
        card_t card;
        card.suit = suit_t'(suit[1:0]);
        card.rank = rank_t'(rank[3:0]);
        return card;
    endfunction

    task automatic check_card(input logic [NAME_W-1:0] name, input card_t exp,
                              input card_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0s: expected suit %0d rank %0d, got suit %0d rank %0d",
                     name, exp.suit, exp.rank, act.suit, act.rank);
        end
    endtask

    task automatic check_flag(input logic [NAME_W-1:0] name, input logic exp,
                              input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0s: expected %0b, got %0b", name, exp, act);
        end
    endtask

    task automatic check_count(input logic [NAME_W-1:0] name, input count_t exp,
                               input count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0s: expected %0d, got %0d", name, exp, act);
        end
    endtask

    task automatic deal_to_column(input int col, input int suit, input int rank);
        deal_valid = 1'b1;
        deal_col   = 3'(col);
        deal_card  = make_card(suit, rank);
        next_cycle();
        deal_valid = 1'b0;
        idle(2);
    endtask

    task automatic write_config(input int cells, input int any);
        cfg_write     = 1'b1;
        cfg_cells     = 3'(cells);
        cfg_empty_any = any[0];
        next_cycle();
        cfg_write = 1'b0;
        idle(2);
    endtask

    task automatic issue_move(input logic [NAME_W-1:0] name, input int src, input int dst,
                              input logic exp_ok);
        int waited;
        move_valid = 1'b1;
        move_src   = loc_t'(src);
        move_dst   = loc_t'(dst);
        next_cycle();
        move_valid = 1'b0;
        waited = 0;
        while (!move_done && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!move_done) begin
            $display("Timeout: move_done never came for %0s", name);
            aborted = 1'b1;
            idle(2);
        end else begin
            check_flag(name, exp_ok, move_ok);
            // The result strobe lasts a single cycle
            next_cycle();
            check_flag(name, 1'b0, move_done);
            idle(1);
        end
    endtask

    task automatic wait_win(input logic [NAME_W-1:0] name);
        int waited;
        waited = 0;
        while (!win && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        check_flag(name, 1'b1, win);
    endtask

    // View port is combinational, so sample a little later in the same cycle
    task automatic inspect_view(input logic [NAME_W-1:0] name, input int loc, input int suit,
                                input int rank);
        view_loc = loc_t'(loc);
        #2;
        check_card(name, make_card(suit, rank), view_card);
        next_cycle();
    endtask

    initial begin
        int                fd;
        int                n;
        int                want;
        int                a;
        int                b;
        int                c;
        int                d;
        logic [LINE_W-1:0] line;
        logic [NAME_W-1:0] op;
        logic [NAME_W-1:0] name;

        clock         = 1'b0;
        arst_n        = 1'b0;
        cfg_write     = 1'b0;
        cfg_cells     = 3'd4;
        cfg_empty_any = 1'b1;
        deal_valid    = 1'b0;
        deal_col      = '0;
        deal_card     = '0;
        move_valid    = 1'b0;
        move_src      = '0;
        move_dst      = '0;
        view_loc      = '0;
        errors        = 0;
        checks        = 0;
        aborted       = 1'b0;

        repeat (3) @(posedge clock);
        #1;
        arst_n = 1'b1;

        fd = $fopen("freecell_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open freecell_tests.txt");
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd)) begin
            line = '0;
            op   = '0;
            name = '0;
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s", op) == 1 && op != "#") begin
                case (op)
                    "win": begin
                        want = 2;
                        n = $sscanf(line, "%s %s", op, name);
                    end
                    "cfg", "stat": begin
                        want = 4;
                        n = $sscanf(line, "%s %d %d %s", op, a, b, name);
                    end
                    "stack": begin
                        want = 6;
                        n = $sscanf(line, "%s %d %d %d %d %s", op, a, b, c, d, name);
                    end
                    default: begin
                        want = 5;
                        n = $sscanf(line, "%s %d %d %d %s", op, a, b, c, name);
                    end
                endcase
                if (n != want) begin
                    $display("Malformed test line: %0s", line);
                    aborted = 1'b1;
                end else begin
                    case (op)
                        "deal":  deal_to_column(a, b, c);
                        "cfg":   write_config(a, b);
                        "move":  issue_move(name, a, b, c[0]);
                        "view":  inspect_view(name, a, b, c);
                        "win":   wait_win(name);
                        "stat": begin
                            check_count(name, count_t'(a), accepted_count);
                            check_count(name, count_t'(b), rejected_count);
                            next_cycle();
                        end
                        // Deal a run from high rank down, so the low rank ends on top
                        "stack": begin
                            for (int r = d; r >= c; r--)
                                deal_to_column(a, b, r);
                        end
                        "drain": begin
                            for (int i = 0; i < c && !aborted; i++)
                                issue_move(name, a, b, 1'b1);
                        end
                        default: begin
                            $display("Unknown operation in test line: %0s", line);
                            aborted = 1'b1;
                        end
                    endcase
                end
            end
        end

        if (fd != 0)
            $fclose(fd);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !aborted)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- freecell_top.sv
`timescale 1ns/1ps

module freecell_top
    import freecell_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic       cfg_write,
    input  logic [2:0] cfg_cells,
    input  logic       cfg_empty_any,
    input  logic       deal_valid,
    input  logic [2:0] deal_col,
    input  card_t      deal_card,
    input  logic       move_valid,
    input  loc_t       move_src,
    input  loc_t       move_dst,
    input  loc_t       view_loc,
    output logic       move_done,
    output logic       move_ok,
    output logic       win,
    output card_t      view_card,
    output count_t     accepted_count,
    output count_t     rejected_count
);

    cell_limit_t cell_limit;
    logic        empty_any;

    logic        col_push, col_pop;
    logic [2:0]  push_col, pop_col;
    card_t       push_card;
    logic [2:0]  read_col_a, read_col_b;
    card_t       col_top_a, col_top_b, view_col_top;
    depth_t      col_depth_b;

    logic        cell_write, cell_clear, home_write, all_kings;
    logic [1:0]  write_index, clear_index;
    card_t       write_card;
    loc_t        read_loc_a, read_loc_b;
    card_t       cell_card_a, cell_card_b, view_cell_card;

    rule_regs u_rules (
        .clock, .arst_n, .cfg_write, .cfg_cells, .cfg_empty_any,
        .move_done, .move_ok, .cell_limit, .empty_any,
        .accepted_count, .rejected_count
    );

    move_engine u_engine (
        .clock, .arst_n, .move_valid, .move_src, .move_dst,
        .deal_valid, .deal_col, .deal_card, .cell_limit, .empty_any,
        .col_top_a, .col_top_b, .col_depth_b, .cell_card_a, .cell_card_b,
        .all_kings, .view_loc, .view_col_top, .view_cell_card,
        .col_push, .col_pop, .push_col, .pop_col, .push_card,
        .cell_write, .cell_clear, .home_write, .write_index, .clear_index,
        .write_card, .read_col_a, .read_col_b, .read_loc_a, .read_loc_b,
        .move_done, .move_ok, .win, .view_card
    );

    // Both stores see the view location, the engine picks the answer
    tableau_store u_tableau (
        .clock, .arst_n, .col_push, .push_col, .push_card, .col_pop, .pop_col,
        .read_col_a, .read_col_b, .view_col(view_loc[2:0]),
        .top_a(col_top_a), .top_b(col_top_b), .depth_b(col_depth_b),
        .view_top(view_col_top)
    );

    cell_store u_cells (
        .clock, .arst_n, .cell_write, .cell_clear, .home_write,
        .write_index, .clear_index, .write_card,
        .read_loc_a, .read_loc_b, .view_loc,
        .card_a(cell_card_a), .card_b(cell_card_b),
        .view_card(view_cell_card), .all_kings
    );

endmodule

//--- move_engine.sv
`timescale 1ns/1ps

module move_engine
    import freecell_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        move_valid,
    input  loc_t        move_src,
    input  loc_t        move_dst,
    input  logic        deal_valid,
    input  logic [2:0]  deal_col,
    input  card_t       deal_card,
    input  cell_limit_t cell_limit,
    input  logic        empty_any,
    input  card_t       col_top_a,
    input  card_t       col_top_b,
    input  depth_t      col_depth_b,
    input  card_t       cell_card_a,
    input  card_t       cell_card_b,
    input  logic        all_kings,
    input  loc_t        view_loc,
    input  card_t       view_col_top,
    input  card_t       view_cell_card,
    output logic        col_push,
    output logic        col_pop,
    output logic [2:0]  push_col,
    output logic [2:0]  pop_col,
    output card_t       push_card,
    output logic        cell_write,
    output logic        cell_clear,
    output logic        home_write,
    output logic [1:0]  write_index,
    output logic [1:0]  clear_index,
    output card_t       write_card,
    output logic [2:0]  read_col_a,
    output logic [2:0]  read_col_b,
    output loc_t        read_loc_a,
    output loc_t        read_loc_b,
    output logic        move_done,
    output logic        move_ok,
    output logic        win,
    output card_t       view_card
);

    logic        pending;
    logic        is_move;
    loc_t        src_q;
    loc_t        dst_q;
    card_t       card_q;
    cell_limit_t limit_q;
    logic        any_q;

    card_t       src_card;
    card_t       dst_card;
    logic        legal;
    logic        deal_fits;
    logic        commit;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
            is_move <= 1'b0;
        end else begin
            pending <= move_valid || deal_valid;
            is_move <= move_valid;
        end
    end

    // Rule options are captured with the move, so a write on the same edge waits
    always_ff @(posedge clock) begin
        if (move_valid) begin
            src_q   <= move_src;
            dst_q   <= move_dst;
            limit_q <= cell_limit;
            any_q   <= empty_any;
        end else if (deal_valid) begin
            dst_q  <= {1'b0, deal_col};
            card_q <= deal_card;
        end
    end

    assign read_col_a = loc_index(src_q);
    assign read_col_b = loc_index(dst_q);
    assign read_loc_a = src_q;
    assign read_loc_b = dst_q;

    assign src_card = loc_is_col(src_q) ? col_top_a : cell_card_a;
    assign dst_card = loc_is_col(dst_q) ? col_top_b : cell_card_b;

    always_comb begin
        legal = 1'b0;
        if (!win && !loc_is_home(src_q) && src_card.rank != '0 && src_q != dst_q) begin
            if (loc_is_cell(dst_q))
                legal = (dst_card.rank == '0) && (loc_index(dst_q) < limit_q);
            else if (loc_is_home(dst_q))
                // Empty pile reads rank 0, so only an ace fits there
                legal = (src_card.suit == suit_t'(dst_q[1:0]))
                     && (src_card.rank == dst_card.rank + 4'd1);
            else if (dst_card.rank != '0)
                legal = (is_red(src_card.suit) != is_red(dst_card.suit))
                     && (src_card.rank + 4'd1 == dst_card.rank)
                     && (col_depth_b < 5'(COL_DEPTH));
            else
                legal = any_q || (src_card.rank == RANK_KING);
        end
    end

    // Deals skip the rules but never overflow a column
    assign deal_fits = col_depth_b < 5'(COL_DEPTH);
    assign commit    = pending && is_move && legal;

    assign col_push    = is_move ? (commit && loc_is_col(dst_q)) : (pending && deal_fits);
    assign push_col    = loc_index(dst_q);
    assign push_card   = is_move ? src_card : card_q;
    assign col_pop     = commit && loc_is_col(src_q);
    assign pop_col     = loc_index(src_q);
    assign cell_write  = commit && loc_is_cell(dst_q);
    assign home_write  = commit && loc_is_home(dst_q);
    assign write_index = dst_q[1:0];
    assign write_card  = src_card;
    assign cell_clear  = commit && loc_is_cell(src_q);
    assign clear_index = src_q[1:0];

    // Result shows one cycle after the commit edge; win follows the home tops
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            move_done <= 1'b0;
            move_ok   <= 1'b0;
            win       <= 1'b0;
        end else begin
            move_done <= pending && is_move;
            move_ok   <= commit;
            win       <= win || all_kings;
        end
    end

    assign view_card = loc_is_col(view_loc) ? view_col_top : view_cell_card;

    one_in_flight: assert property (@(posedge clock) disable iff (!arst_n)
        pending |-> !(move_valid || deal_valid));

endmodule

//--- cell_store.sv
`timescale 1ns/1ps

module cell_store
    import freecell_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic       cell_write,
    input  logic       cell_clear,
    input  logic       home_write,
    input  logic [1:0] write_index,
    input  logic [1:0] clear_index,
    input  card_t      write_card,
    input  loc_t       read_loc_a,
    input  loc_t       read_loc_b,
    input  loc_t       view_loc,
    output card_t      card_a,
    output card_t      card_b,
    output card_t      view_card,
    output logic       all_kings
);

    card_t cells     [NUM_CELLS];
    rank_t home_rank [4];

    // Home piles keep only their top rank and take the suit from the pile index
    function automatic card_t read_loc(input loc_t loc);
        logic [1:0] idx;
        idx = loc[1:0];
        if (loc_is_cell(loc))
            return cells[idx];
        if (loc_is_home(loc) && home_rank[idx] != '0)
            return '{suit: suit_t'(idx), rank: home_rank[idx]};
        return EMPTY_CARD;
    endfunction

    always_comb begin
        card_a    = read_loc(read_loc_a);
        card_b    = read_loc(read_loc_b);
        view_card = read_loc(view_loc);
        all_kings = 1'b1;
        for (int s = 0; s < 4; s++)
            all_kings &= (home_rank[s] == RANK_KING);
    end

    // A cell-to-cell move writes one cell and clears another on the same edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_CELLS; i++)
                cells[i] <= EMPTY_CARD;
            for (int s = 0; s < 4; s++)
                home_rank[s] <= '0;
        end else begin
            if (cell_clear)
                cells[clear_index] <= EMPTY_CARD;
            if (cell_write)
                cells[write_index] <= write_card;
            if (home_write)
                home_rank[write_index] <= write_card.rank;
        end
    end

endmodule

//--- tableau_store.sv
`timescale 1ns/1ps

module tableau_store
    import freecell_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic       col_push,
    input  logic [2:0] push_col,
    input  card_t      push_card,
    input  logic       col_pop,
    input  logic [2:0] pop_col,
    input  logic [2:0] read_col_a,
    input  logic [2:0] read_col_b,
    input  logic [2:0] view_col,
    output card_t      top_a,
    output card_t      top_b,
    output depth_t     depth_b,
    output card_t      view_top
);

    card_t  stack [NUM_COLS][COL_DEPTH];
    depth_t depth [NUM_COLS];

    // Card just below the depth pointer, empty for a bare column
    function automatic card_t top_of(input logic [2:0] col);
        if (depth[col] == '0)
            return EMPTY_CARD;
        return stack[col][depth[col] - 1'b1];
    endfunction

    always_comb begin
        top_a    = top_of(read_col_a);
        top_b    = top_of(read_col_b);
        view_top = top_of(view_col);
        depth_b  = depth[read_col_b];
    end

    // Slot contents are only meaningful below the depth pointer
    always_ff @(posedge clock) begin
        if (col_push)
            stack[push_col][depth[push_col]] <= push_card;
    end

    // Push and pop come from different columns within one move
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < NUM_COLS; c++)
                depth[c] <= '0;
        end else begin
            if (col_push)
                depth[push_col] <= depth[push_col] + 1'b1;
            if (col_pop)
                depth[pop_col] <= depth[pop_col] - 1'b1;
        end
    end

    push_not_full: assert property (@(posedge clock) disable iff (!arst_n)
        col_push |-> depth[push_col] < 5'(COL_DEPTH));

    pop_not_empty: assert property (@(posedge clock) disable iff (!arst_n)
        col_pop |-> depth[pop_col] != '0);

endmodule

//--- rule_regs.sv
`timescale 1ns/1ps

module rule_regs
    import freecell_pkg::*;
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        cfg_write,
    input  logic [2:0]  cfg_cells,
    input  logic        cfg_empty_any,
    input  logic        move_done,
    input  logic        move_ok,
    output cell_limit_t cell_limit,
    output logic        empty_any,
    output count_t      accepted_count,
    output count_t      rejected_count
);

    cell_limit_t cells_clamped;

    // Keep at least one usable cell and no more than exist
    always_comb begin
        if (cfg_cells == 3'd0)
            cells_clamped = 3'd1;
        else if (cfg_cells > 3'(NUM_CELLS))
            cells_clamped = 3'(NUM_CELLS);
        else
            cells_clamped = cfg_cells;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cell_limit <= 3'(NUM_CELLS);
            empty_any  <= 1'b1;
        end else if (cfg_write) begin
            cell_limit <= cells_clamped;
            empty_any  <= cfg_empty_any;
        end
    end

    // Result counters fed by the engine's one-cycle result strobe
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            accepted_count <= '0;
            rejected_count <= '0;
        end else if (move_done) begin
            if (move_ok)
                accepted_count <= accepted_count + 1'b1;
            else
                rejected_count <= rejected_count + 1'b1;
        end
    end

    ok_needs_done: assert property (@(posedge clock) disable iff (!arst_n)
        move_ok |-> move_done);

endmodule

//--- freecell_pkg.sv
package freecell_pkg;

    typedef enum logic [1:0] {
        HEARTS   = 2'd0,
        SPADES   = 2'd1,
        CLUBS    = 2'd2,
        DIAMONDS = 2'd3
    } suit_t;

    // Rank 0 marks an empty slot
    typedef logic [3:0] rank_t;

    typedef struct packed {
        suit_t suit;
        rank_t rank;
    } card_t;

    // 0..7 column, 8..11 free cell, 12..15 home pile by suit
    typedef logic [3:0] loc_t;

    typedef logic [15:0] count_t;
    typedef logic [4:0]  depth_t;
    typedef logic [2:0]  cell_limit_t;

    localparam int NUM_COLS  = 8;
    localparam int COL_DEPTH = 20;
    localparam int NUM_CELLS = 4;

    localparam rank_t RANK_KING  = 4'd13;
    localparam card_t EMPTY_CARD = '0;

    function automatic logic is_red(input suit_t suit);
        return (suit == HEARTS) || (suit == DIAMONDS);
    endfunction

    function automatic logic loc_is_col(input loc_t loc);
        return !loc[3];
    endfunction

    function automatic logic loc_is_cell(input loc_t loc);
        return loc[3:2] == 2'b10;
    endfunction

    function automatic logic loc_is_home(input loc_t loc);
        return loc[3:2] == 2'b11;
    endfunction

    // Column number, cell number or suit, depending on the location kind
    function automatic logic [2:0] loc_index(input loc_t loc);
        return loc[3] ? {1'b0, loc[1:0]} : loc[2:0];
    endfunction

endpackage
